/* hdl/snes_consts.svh */
`ifndef SNES_CONSTS_SVH
`define SNES_CONSTS_SVH

// rom and save-ram mask width
`define SNES_ROM_ADDR_BITS 24

// work ram byte address width
// also the full fill depth
`define SNES_WRAM_ADDR_BITS 17

// header size field counts in 1 KiB steps
`define SNES_MASK_UNIT 1024

// cycles for the header parser to settle after download ends
`define SNES_PARSER_DELAY 6

// fill bytes for the work ram clear
`define SNES_FILL_A 8'h66
`define SNES_FILL_B 8'h99
`define SNES_FILL_55 8'h55
`define SNES_FILL_ONES 8'hFF
`define SNES_FILL_ZERO 8'h00

`endif

/* hdl/snes_pkg.sv */
`include "snes_consts.svh"

package snes_pkg;

  // work ram fill pattern select
  typedef enum logic [1:0] {
    FILL_CHECKER = 2'd0,
    FILL_STRIPE  = 2'd1,
    FILL_55      = 2'd2,
    FILL_ONES    = 2'd3
  } fill_mode_t;

  // clear master states
  typedef enum logic [1:0] {
    CLR_IDLE  = 2'd0,
    CLR_WRITE = 2'd1,
    CLR_DONE  = 2'd2
  } clear_state_t;

  // wishbone classic, master to slave half
  // ack comes back as a plain bit
  typedef struct packed {
    logic                            cyc;
    logic                            stb;
    logic                            we;
    logic [`SNES_WRAM_ADDR_BITS-1:0] adr;
    logic [7:0]                      dat;
  } wb_req_t;

  // masks handed to the core once the header is parsed
  typedef struct packed {
    logic [`SNES_ROM_ADDR_BITS-1:0] rom_mask;
    logic [`SNES_ROM_ADDR_BITS-1:0] ram_mask;
    logic [3:0]                     sram_size;
  } mem_masks_t;

  // size fields from the cartridge header
  typedef struct packed {
    logic [3:0] rom_size;
    logic [3:0] ram_size;
  } cart_geom_t;

endpackage

/* hdl/cart_loader.sv */
`timescale 1ns/100ps
`include "snes_consts.svh"

module cart_loader (
  input  logic                   clk_sys,
  input  logic                   reset,
  input  logic                   cart_download,
  input  snes_pkg::cart_geom_t   cart_geom,
  output logic                   clear_start,
  output logic                   loader_busy,
  output snes_pkg::mem_masks_t   masks
);

  // counter just wide enough for the settle delay
  localparam int cnt_bits = $clog2(`SNES_PARSER_DELAY + 1);

  // one size step in mask width
  localparam logic [`SNES_ROM_ADDR_BITS-1:0] mask_unit = `SNES_MASK_UNIT;

  logic                prev_download;
  logic                dl_rise;
  logic                dl_fall;
  logic [cnt_bits-1:0] delay_cnt;
  logic                delay_last;

  // header size code to address mask
  // 1 KiB shifted by size, minus one
  function automatic logic [`SNES_ROM_ADDR_BITS-1:0] size_to_mask(
    input logic [3:0] size
  );
    size_to_mask = (mask_unit << size) - 1'b1;
  endfunction

  // both edges of the download strobe
  assign dl_rise = cart_download & ~prev_download;
  assign dl_fall = prev_download & ~cart_download;

  // final settle cycle
  assign delay_last = (delay_cnt == cnt_bits'(1));

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      prev_download <= 1'b0;
      clear_start   <= 1'b0;
      loader_busy   <= 1'b0;
      delay_cnt     <= '0;
      masks         <= '0;
    end else begin
      prev_download <= cart_download;

      // single pulse kicks off the work ram clear
      clear_start <= dl_rise;

      // busy through the download and the whole settle window
      loader_busy <= cart_download | dl_fall | (delay_cnt != '0);

      // reload on download end, then run down to zero
      if (dl_fall) begin
        delay_cnt <= cnt_bits'(`SNES_PARSER_DELAY);
      end else if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end

      // parser is settled, masks ready before the core starts
      if (delay_last) begin
        masks.rom_mask  <= size_to_mask(cart_geom.rom_size);
        // no save ram means an empty mask
        masks.ram_mask  <= (cart_geom.ram_size == 4'd0) ? '0
                                                        : size_to_mask(cart_geom.ram_size);
        masks.sram_size <= cart_geom.ram_size;
      end
    end
  end

  // a fresh settle count only ever follows a low download
  a_reload_after_download: assert property (
    @(posedge clk_sys) disable iff (!reset)
    (delay_cnt == cnt_bits'(`SNES_PARSER_DELAY)) |-> !$past(cart_download)
  ) else $error("parser delay reloaded while cart_download high");

endmodule

/* hdl/wram_clear.sv */
`timescale 1ns/100ps
`include "snes_consts.svh"

module wram_clear #(
  parameter int fill_addr_bits = `SNES_WRAM_ADDR_BITS
) (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  logic                 clear_start,
  input  snes_pkg::fill_mode_t fill_mode,
  input  logic                 wb_ack,
  output snes_pkg::wb_req_t    wb_req,
  output logic                 clear_busy
);

  snes_pkg::clear_state_t          state;
  snes_pkg::fill_mode_t            mode_q;
  logic [fill_addr_bits-1:0]       fill_addr;
  logic [`SNES_WRAM_ADDR_BITS-1:0] adr_ext;
  logic                            start_ok;
  logic                            last_addr;

  // fill byte from pattern select and byte address
  function automatic logic [7:0] fill_byte(
    input snes_pkg::fill_mode_t            mode,
    input logic [`SNES_WRAM_ADDR_BITS-1:0] addr
  );
    case (mode)
      // checkerboard of 66 and 99
      snes_pkg::FILL_CHECKER:
        fill_byte = (addr[8] ^ addr[2]) ? `SNES_FILL_A : `SNES_FILL_B;
      // stripes of ff and 00
      snes_pkg::FILL_STRIPE:
        fill_byte = (addr[9] ^ addr[0]) ? `SNES_FILL_ONES : `SNES_FILL_ZERO;
      snes_pkg::FILL_55:
        fill_byte = `SNES_FILL_55;
      default:
        fill_byte = `SNES_FILL_ONES;
    endcase
  endfunction

  // a start during a running clear is ignored
  assign start_ok  = clear_start && (state != snes_pkg::CLR_WRITE);
  assign last_addr = &fill_addr;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state     <= snes_pkg::CLR_IDLE;
      fill_addr <= '0;
    end else begin
      case (state)
        snes_pkg::CLR_IDLE: begin
          if (start_ok) begin
            state     <= snes_pkg::CLR_WRITE;
            fill_addr <= '0;
          end
        end
        snes_pkg::CLR_WRITE: begin
          // step only on ack, slave may stall as long as it likes
          if (wb_ack) begin
            if (last_addr) begin
              state <= snes_pkg::CLR_DONE;
            end else begin
              fill_addr <= fill_addr + 1'b1;
            end
          end
        end
        snes_pkg::CLR_DONE: begin
          // one trailing busy cycle, back to back start allowed
          if (start_ok) begin
            state     <= snes_pkg::CLR_WRITE;
            fill_addr <= '0;
          end else begin
            state <= snes_pkg::CLR_IDLE;
          end
        end
        default: state <= snes_pkg::CLR_IDLE;
      endcase
    end
  end

  // pattern held for the whole clear
  always_ff @(posedge clk_sys) begin
    if (start_ok) begin
      mode_q <= fill_mode;
    end
  end

  // bus outputs straight from registered state
  // adr and dat move only after an ack
  always_comb begin
    adr_ext                     = '0;
    adr_ext[fill_addr_bits-1:0] = fill_addr;
    wb_req.cyc                  = (state == snes_pkg::CLR_WRITE);
    wb_req.stb                  = (state == snes_pkg::CLR_WRITE);
    wb_req.we                   = (state == snes_pkg::CLR_WRITE);
    wb_req.adr                  = adr_ext;
    wb_req.dat                  = fill_byte(mode_q, adr_ext);
  end

  assign clear_busy = (state != snes_pkg::CLR_IDLE);

  // stalled write keeps strobe, address and data
  a_wb_hold: assert property (
    @(posedge clk_sys) disable iff (!reset)
    (wb_req.stb && !wb_ack) |=> wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.dat)
  ) else $error("wishbone request changed before ack");

  // strobe only while writing
  a_stb_in_write: assert property (
    @(posedge clk_sys) disable iff (!reset)
    wb_req.stb |-> (state == snes_pkg::CLR_WRITE)
  ) else $error("wishbone stb outside CLR_WRITE");

endmodule

/* hdl/reset_gen.sv */
`timescale 1ns/100ps

module reset_gen (
  input  logic clk_sys,
  input  logic reset,
  input  logic core_reset,
  input  logic loader_busy,
  input  logic clear_busy,
  output logic core_reset_n,
  output logic refresh
);

  // divide by four cadence
  logic [1:0] phase;

  // any source holding the core in reset
  logic reset_req;

  assign reset_req = core_reset | loader_busy | clear_busy;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      phase        <= 2'd0;
      refresh      <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      phase <= phase + 2'd1;

      // one refresh per four cycles
      refresh <= (phase == 2'd0);

      // release only on phase 2
      // keeps core start in step with refresh
      if (phase == 2'd2) begin
        core_reset_n <= ~reset_req;
      end
    end
  end

  // refresh is a single cycle strobe
  a_refresh_single: assert property (
    @(posedge clk_sys) disable iff (!reset)
    refresh |=> !refresh
  ) else $error("refresh high two cycles in a row");

endmodule

/* hdl/snes_load_ctrl.sv */
`timescale 1ns/100ps
`include "snes_consts.svh"

module snes_load_ctrl #(
  parameter int fill_addr_bits = `SNES_WRAM_ADDR_BITS
) (
  input  logic                 clk_sys,
  input  logic                 reset,
  input  logic                 core_reset,
  input  logic                 cart_download,
  input  snes_pkg::cart_geom_t cart_geom,
  input  snes_pkg::fill_mode_t fill_mode,
  input  logic                 wb_ack,
  output snes_pkg::mem_masks_t masks,
  output logic                 core_reset_n,
  output logic                 refresh,
  output snes_pkg::wb_req_t    wb_req
);

  // download start, kicks the clear
  logic clear_start;

  // reset holds from the loader and the clear
  logic loader_busy;
  logic clear_busy;

  // rom detect
  // download edges, parser settle and mask latch
  cart_loader i_cart_loader (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .cart_geom     (cart_geom),
    .clear_start   (clear_start),
    .loader_busy   (loader_busy),
    .masks         (masks)
  );

  // memory clear
  // wishbone master over the whole work ram
  wram_clear #(
    .fill_addr_bits (fill_addr_bits)
  ) i_wram_clear (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .clear_start (clear_start),
    .fill_mode   (fill_mode),
    .wb_ack      (wb_ack),
    .wb_req      (wb_req),
    .clear_busy  (clear_busy)
  );

  // system reset
  // refresh cadence and gated core reset
  reset_gen i_reset_gen (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .core_reset   (core_reset),
    .loader_busy  (loader_busy),
    .clear_busy   (clear_busy),
    .core_reset_n (core_reset_n),
    .refresh      (refresh)
  );

endmodule

/* tb/tb_snes_load.sv */
`timescale 1ns/100ps

module tb_snes_load;

  // small work ram keeps each clear short
  localparam int fill_bits = 10;
  localparam int clear_words = 1 << fill_bits;
  // slowest write, two bus cycles plus three wait states
  localparam int write_cycles = 5;
  localparam int timeout_cycles = 4 * 3 * clear_words * write_cycles;

  // dut inputs
  logic                 clk_sys = 1'b0;
  logic                 reset = 1'b0;
  logic                 core_reset = 1'b1;
  logic                 cart_download = 1'b0;
  snes_pkg::cart_geom_t cart_geom = '0;
  snes_pkg::fill_mode_t fill_mode = snes_pkg::FILL_CHECKER;
  logic                 wb_ack = 1'b0;

  // dut outputs
  snes_pkg::mem_masks_t masks;
  logic                 core_reset_n;
  logic                 refresh;
  snes_pkg::wb_req_t    wb_req;

  // pattern and header of the load in progress
  snes_pkg::fill_mode_t cur_mode = snes_pkg::FILL_CHECKER;
  snes_pkg::cart_geom_t cur_geom = '0;

  // wishbone slave model
  logic [31:0] rng = 32'hc188_06da;
  logic        req_open = 1'b0;
  logic [1:0]  ack_wait = 2'd0;

  // reference trackers
  int   cycle_count = 0;
  logic seen_download = 1'b0;
  logic dl_prev = 1'b0;
  logic cyc_prev = 1'b0;
  int   tail_cnt = 0;
  int   write_count = 0;
  int   ref_gap = 0;
  int   busy_run = 0;
  int   idle_run = 0;

  // error counts per check group
  int err_reset = 0;
  int err_addr = 0;
  int err_data = 0;
  int err_count = 0;
  int err_hold = 0;
  int err_masks = 0;
  int err_refresh = 0;
  int err_core = 0;

  snes_load_ctrl #(
    .fill_addr_bits (fill_bits)
  ) i_snes_load_ctrl (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .core_reset    (core_reset),
    .cart_download (cart_download),
    .cart_geom     (cart_geom),
    .fill_mode     (fill_mode),
    .wb_ack        (wb_ack),
    .masks         (masks),
    .core_reset_n  (core_reset_n),
    .refresh       (refresh),
    .wb_req        (wb_req)
  );

  // 4 ns period
  always #2 clk_sys = ~clk_sys;

  // xorshift32 step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected work ram byte for a pattern and address
  function automatic logic [7:0] pattern_byte(
    input snes_pkg::fill_mode_t mode,
    input logic [16:0]          a
  );
    case (mode)
      snes_pkg::FILL_CHECKER: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
      snes_pkg::FILL_STRIPE:  return (a[9] ^ a[0]) ? 8'hff : 8'h00;
      snes_pkg::FILL_55:      return 8'h55;
      default:                return 8'hff;
    endcase
  endfunction

  // 1 KiB shifted by the size code, minus one
  function automatic snes_pkg::mem_masks_t expected_masks(input snes_pkg::cart_geom_t g);
    snes_pkg::mem_masks_t m;
    logic [31:0]          span;
    span = (32'd1024 << g.rom_size) - 32'd1;
    m.rom_mask = span[23:0];
    span = (32'd1024 << g.ram_size) - 32'd1;
    // no save ram gives an empty mask
    m.ram_mask = (g.ram_size == 4'd0) ? 24'd0 : span[23:0];
    m.sram_size = g.ram_size;
    return m;
  endfunction

  // slave acks after 0 to 3 wait states
  always @(posedge clk_sys) begin
    if (!reset) begin
      wb_ack   <= 1'b0;
      req_open <= 1'b0;
      ack_wait <= 2'd0;
    end else if (wb_ack) begin
      // one cycle ack completes the write
      wb_ack   <= 1'b0;
      req_open <= 1'b0;
    end else if (wb_req.stb && !req_open) begin
      rng = next_random(rng);
      req_open <= 1'b1;
      ack_wait <= rng[1:0];
      wb_ack   <= (rng[1:0] == 2'd0);
    end else if (req_open) begin
      ack_wait <= ack_wait - 2'd1;
      wb_ack   <= (ack_wait == 2'd1);
    end
  end

  // reference state from the load and bus rules
  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (!reset) begin
      seen_download <= 1'b0;
      dl_prev       <= 1'b0;
      cyc_prev      <= 1'b0;
      tail_cnt      <= 0;
      write_count   <= 0;
      ref_gap       <= 0;
      busy_run      <= 0;
      idle_run      <= 0;
    end else begin
      dl_prev  <= cart_download;
      cyc_prev <= wb_req.cyc;
      if (cart_download) begin
        seen_download <= 1'b1;
      end
      // loader holds 7 cycles past the download end
      if (dl_prev && !cart_download) begin
        tail_cnt <= 7;
      end else if (tail_cnt != 0) begin
        tail_cnt <= tail_cnt - 1;
      end
      // acked writes of the current clear
      if (wb_req.stb && wb_ack) begin
        write_count <= write_count + 1;
      end else if (!wb_req.cyc && !cyc_prev) begin
        write_count <= 0;
      end
      // cycles since the last refresh, zero before the first
      if (refresh) begin
        ref_gap <= 1;
      end else if (ref_gap != 0 && ref_gap < 15) begin
        ref_gap <= ref_gap + 1;
      end
      // run lengths of held and idle reset sources
      if (core_reset || cart_download || wb_req.stb) begin
        busy_run <= busy_run + 1;
      end else begin
        busy_run <= 0;
      end
      if (core_reset || cart_download || dl_prev || tail_cnt != 0 || wb_req.cyc) begin
        idle_run <= 0;
      end else begin
        idle_run <= idle_run + 1;
      end
    end
  end

  // reset values one cycle into reset
  chk_reset_values: assert property (
    @(posedge clk_sys) !reset |=> (!core_reset_n && !refresh && !wb_req.cyc && !wb_req.stb
                                   && masks == '0)
  ) else begin
    err_reset = err_reset + 1;
    $display("outputs not at their reset values during reset");
  end

  // quiet until the first download
  chk_pre_load: assert property (
    @(posedge clk_sys) disable iff (!reset)
    !seen_download |-> (!core_reset_n && !wb_req.cyc && !wb_req.stb && masks == '0)
  ) else begin
    err_reset = err_reset + 1;
    $display("core released or bus active before the first download");
  end

  // ascending address, one per ack
  chk_wb_addr: assert property (
    @(posedge clk_sys) disable iff (!reset)
    (wb_req.stb && wb_ack) |-> wb_req.adr == 17'(write_count)
  ) else begin
    err_addr = err_addr + 1;
    $display("ERROR wb_req.adr got %h expected %h", $sampled(wb_req.adr),
             17'($sampled(write_count)));
  end

  // fill pattern latched at clear start
  chk_wb_data: assert property (
    @(posedge clk_sys) disable iff (!reset)
    (wb_req.stb && wb_ack) |-> wb_req.dat == pattern_byte(cur_mode, wb_req.adr)
  ) else begin
    err_data = err_data + 1;
    $display("ERROR wb_req.dat got %h expected %h", $sampled(wb_req.dat),
             pattern_byte($sampled(cur_mode), $sampled(wb_req.adr)));
  end

  // every word written once per clear
  chk_wb_count: assert property (
    @(posedge clk_sys) disable iff (!reset)
    $fell(wb_req.cyc) |-> write_count == clear_words
  ) else begin
    err_count = err_count + 1;
    $display("ERROR write_count got %h expected %h", $sampled(write_count), clear_words);
  end

  // stalled write holds address and data
  chk_wb_hold: assert property (
    @(posedge clk_sys) disable iff (!reset)
    (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.dat))
  ) else begin
    err_hold = err_hold + 1;
    $display("wishbone request dropped or changed while waiting for ack");
  end

  chk_wb_cyc: assert property (
    @(posedge clk_sys) disable iff (!reset)
    wb_req.stb |-> (wb_req.cyc && wb_req.we)
  ) else begin
    err_hold = err_hold + 1;
    $display("wishbone stb high without cyc and we");
  end

  // last settle cycle carries the new masks
  chk_masks_value: assert property (
    @(posedge clk_sys) disable iff (!reset)
    tail_cnt == 1 |-> masks == expected_masks(cur_geom)
  ) else begin
    err_masks = err_masks + 1;
    $display("ERROR masks got %h expected %h", $sampled(masks),
             expected_masks($sampled(cur_geom)));
  end

  chk_masks_hold: assert property (
    @(posedge clk_sys) disable iff (!reset)
    tail_cnt != 1 |-> $stable(masks)
  ) else begin
    err_masks = err_masks + 1;
    $display("masks changed outside the parser settle cycle");
  end

  // one refresh in every four cycles
  chk_refresh: assert property (
    @(posedge clk_sys) disable iff (!reset)
    ref_gap != 0 |-> (refresh == (ref_gap == 4))
  ) else begin
    err_refresh = err_refresh + 1;
    $display("refresh out of cadence, %0d cycles after the previous pulse", $sampled(ref_gap));
  end

  // held source keeps the core in reset
  chk_core_hold: assert property (
    @(posedge clk_sys) disable iff (!reset)
    busy_run >= 6 |-> !core_reset_n
  ) else begin
    err_core = err_core + 1;
    $display("ERROR core_reset_n got %h expected %h", $sampled(core_reset_n), 1'b0);
  end

  // release within eight idle cycles
  chk_core_release: assert property (
    @(posedge clk_sys) disable iff (!reset)
    idle_run >= 8 |-> core_reset_n
  ) else begin
    err_core = err_core + 1;
    $display("ERROR core_reset_n got %h expected %h", $sampled(core_reset_n), 1'b1);
  end

  task automatic end_run(input logic timed_out);
    int total;
    total = err_reset + err_addr + err_data + err_count + err_hold + err_masks
            + err_refresh + err_core;
    $display({"errors: reset=%0d addr=%0d data=%0d count=%0d hold=%0d masks=%0d",
              " refresh=%0d core=%0d"},
             err_reset, err_addr, err_data, err_count, err_hold, err_masks, err_refresh, err_core);
    if (!timed_out && total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // one cartridge load, pattern switched mid clear
  task automatic run_load(
    input snes_pkg::fill_mode_t mode,
    input snes_pkg::fill_mode_t late_mode,
    input snes_pkg::cart_geom_t geom,
    input int                   dl_cycles
  );
    @(posedge clk_sys);
    cur_mode = mode;
    cur_geom = geom;
    fill_mode <= mode;
    cart_geom <= geom;
    @(posedge clk_sys);
    cart_download <= 1'b1;
    // loader already holds the core when core_reset drops
    repeat (4) @(posedge clk_sys);
    core_reset <= 1'b0;
    fill_mode  <= late_mode;
    repeat (dl_cycles) @(posedge clk_sys);
    cart_download <= 1'b0;
    // release marks both clear and mask latch done
    @(posedge clk_sys);
    while (!core_reset_n) @(posedge clk_sys);
  endtask

  initial begin : watchdog
    wait (cycle_count >= timeout_cycles);
    $display("timeout after %0d cycles, a clear or the core release never finished",
             cycle_count);
    end_run(1'b1);
  end

  initial begin
    repeat (16) @(posedge clk_sys);
    reset <= 1'b1;
    repeat (8) @(posedge clk_sys);
    // download shorter than the clear
    run_load(snes_pkg::FILL_CHECKER, snes_pkg::FILL_ONES,
             '{rom_size: 4'hb, ram_size: 4'h3}, 300);
    // long download, no save ram
    run_load(snes_pkg::FILL_STRIPE, snes_pkg::FILL_55,
             '{rom_size: 4'h9, ram_size: 4'h0}, 4500);
    run_load(snes_pkg::FILL_55, snes_pkg::FILL_CHECKER,
             '{rom_size: 4'hc, ram_size: 4'h5}, 50);
    // core_reset on its own
    repeat (12) @(posedge clk_sys);
    core_reset <= 1'b1;
    repeat (20) @(posedge clk_sys);
    core_reset <= 1'b0;
    @(posedge clk_sys);
    while (!core_reset_n) @(posedge clk_sys);
    repeat (16) @(posedge clk_sys);
    end_run(1'b0);
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/snes_pkg.sv
hdl/cart_loader.sv
hdl/wram_clear.sv
hdl/reset_gen.sv
hdl/snes_load_ctrl.sv
tb/tb_snes_load.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_snes_load -f verilog.f -o sim_snes_load

out=$(./obj_dir/sim_snes_load)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
